// File: flist.f
logic/sdcard_pkg.sv
logic/sdcard_ifs.sv
logic/sdcard_crc7.sv
logic/sdcard_cmd_rx.sv
logic/sdcard_cmd_ctrl.sv
logic/sdcard_resp_tx.sv
logic/sdcard_cmd_top.sv
testbench/sdcard_checker.sv
testbench/sdcard_tb.sv

// File: Makefile
# Verilator build and run for the SD card CMD line model

VERILATOR ?= verilator
TOP       ?= sdcard_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/sdcard_tb.sv
/* Directed testbench for the SD card CMD line model
   Host frame driver, response capture, six test tasks and the closing report */
`default_nettype none

module sdcard_tb;

    localparam int          INIT_CLOCKS = 74;
    localparam logic [31:0] OCR_VALUE   = 32'h00FF_8000;
    localparam int          READY_AFTER = 2;
    localparam logic [15:0] RCA_VALUE   = 16'h1234;
    localparam int          TIMEOUT     = 4000;     // Six tests of a few frames each

    logic                    i_clk;
    logic                    i_nrst;
    logic                    i_cmd;
    logic                    o_cmd;
    logic                    o_cmd_oe;
    logic                    o_busy;
    sdcard_pkg::card_state_t o_card_state;

    int     cyc = 0;
    int     checks;
    int     errors;
    integer seed;

    sdcard_cmd_top #(
        .INIT_CLOCKS (INIT_CLOCKS),
        .OCR_VALUE   (OCR_VALUE),
        .READY_AFTER (READY_AFTER),
        .RCA_VALUE   (RCA_VALUE)
    ) DUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_cmd        (i_cmd),
        .o_cmd        (o_cmd),
        .o_cmd_oe     (o_cmd_oe),
        .o_busy       (o_busy),
        .o_card_state (o_card_state)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    function automatic logic [31:0] status_word(input logic [3:0] state, input bit crc_e,
                                                input bit ill, input bit app);
        logic [31:0] w;
        w = '0;
        w[12:9] = state;
        w[sdcard_pkg::STAT_CRC_BIT]     = crc_e;
        w[sdcard_pkg::STAT_ILLEGAL_BIT] = ill;
        w[sdcard_pkg::STAT_APP_BIT]     = app;
        return w;
    endfunction

    task automatic finish_run(input bit timed_out);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc == TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
            finish_run(1'b1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Host side: idle gap, 48-bit frame, then release to high
    task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg, input bit bad_crc);
        logic [6:0]  crc;
        logic [47:0] frame;
        crc = crc7_of({2'b01, idx, arg});
        if (bad_crc) begin
            crc = crc ^ 7'h01;
        end
        frame = {2'b01, idx, arg, crc, 1'b1};
        repeat (2) @(posedge i_clk);
        for (int i = 47; i >= 0; i--) begin
            @(posedge i_clk);
            i_cmd <= frame[i];
        end
        @(posedge i_clk);
        i_cmd <= 1'b1;
    endtask

    task automatic capture_resp(input bit expected, output bit got, output logic [47:0] frame);
        got   = 1'b0;
        frame = '1;
        for (int n = 0; n < 10 && !got; n++) begin
            @(negedge i_clk);
            got = o_cmd_oe && !o_cmd;           // Start bit seen
        end
        if (got) begin
            frame[47] = 1'b0;
            for (int i = 46; i >= 0; i--) begin
                @(negedge i_clk);
                frame[i] = o_cmd;
            end
        end
        checks++;
        if (expected) begin
            assert (got) else begin
                errors++;
                $display("No response from the card within 10 cycles");
            end
        end else begin
            assert (!got) else begin
                errors++;
                $display("Card answered a command that needs no response");
            end
        end
    endtask

    task automatic expect_resp(input string name, input sdcard_pkg::resp_kind_t kind,
                               input logic [5:0] idx, input logic [31:0] payload);
        logic [47:0] f;
        bit          got;
        bit          is_r3;
        logic [6:0]  crc;
        capture_resp(1'b1, got, f);
        is_r3 = (kind == sdcard_pkg::R3);
        crc   = is_r3 ? 7'h7F : crc7_of({2'b00, idx, payload});
        if (got) begin
            check_eq({"o_cmd ", name, " direction"}, 32'(f[46]), 32'd0);
            check_eq({"o_cmd ", name, " index"}, 32'(f[45:40]), is_r3 ? 32'h3F : 32'(idx));
            check_eq({"o_cmd ", name, " payload"}, f[39:8], payload);
            check_eq({"o_cmd ", name, " crc7"}, 32'(f[7:1]), 32'(crc));
            check_eq({"o_cmd ", name, " stop bit"}, 32'(f[0]), 32'd1);
        end
    endtask

    task automatic power_up();
        int          start;
        bit          got;
        logic [47:0] f;
        $display("Power-up and busy period");
        @(negedge i_clk);
        start = cyc;
        check_eq("o_busy", 32'(o_busy), 32'd1);
        check_eq("o_card_state", 32'(o_card_state), 32'(sdcard_pkg::IDLE));
        check_eq("o_cmd_oe", 32'(o_cmd_oe), 32'd0);
        send_cmd(sdcard_pkg::CMD_GO_IDLE, 32'd0, 1'b0);   // Ignored while busy
        capture_resp(1'b0, got, f);
        while (o_busy) begin
            @(negedge i_clk);
        end
        check_eq("o_busy high cycles", 32'(cyc - start), 32'(INIT_CLOCKS));
    endtask

    task automatic send_if_cond();
        logic [31:0] arg;
        $display("CMD8 echo");
        arg = $random(seed);
        send_cmd(sdcard_pkg::CMD_SEND_IF_COND, arg, 1'b0);
        expect_resp("R7", sdcard_pkg::R7, sdcard_pkg::CMD_SEND_IF_COND, {20'd0, arg[11:0]});
    endtask

    task automatic init_sequence();
        logic [31:0] ocr;
        $display("CMD55 and ACMD41 init loop");
        for (int k = 1; k <= READY_AFTER; k++) begin
            send_cmd(sdcard_pkg::CMD_APP, 32'd0, 1'b0);
            expect_resp("R1", sdcard_pkg::R1, sdcard_pkg::CMD_APP,
                        status_word(sdcard_pkg::IDLE, 1'b0, 1'b0, 1'b1));
            ocr     = OCR_VALUE;
            ocr[31] = (k == READY_AFTER);               // Busy bit clears on the last call
            send_cmd(sdcard_pkg::CMD_SEND_OP_COND, 32'h4030_0000, 1'b0);
            expect_resp("R3", sdcard_pkg::R3, sdcard_pkg::CMD_SEND_OP_COND, ocr);
        end
        check_eq("o_card_state", 32'(o_card_state), 32'(sdcard_pkg::READY));
    endtask

    task automatic assign_rca();
        logic [31:0] st;
        $display("CMD3 relative address");
        st = status_word(sdcard_pkg::READY, 1'b0, 1'b0, 1'b0);
        send_cmd(sdcard_pkg::CMD_SEND_RCA, 32'd0, 1'b0);
        expect_resp("R6", sdcard_pkg::R6, sdcard_pkg::CMD_SEND_RCA,
                    {RCA_VALUE, 3'b000, st[12:0]});
        check_eq("o_card_state", 32'(o_card_state), 32'(sdcard_pkg::STBY));
    endtask

    task automatic error_flags();
        bit          got;
        logic [47:0] f;
        $display("CRC and illegal command flags");
        send_cmd(sdcard_pkg::CMD_APP, 32'd0, 1'b1);
        capture_resp(1'b0, got, f);
        send_cmd(6'd2, 32'd0, 1'b0);                    // Not supported by the card
        capture_resp(1'b0, got, f);
        send_cmd(sdcard_pkg::CMD_APP, 32'd0, 1'b0);
        expect_resp("R1", sdcard_pkg::R1, sdcard_pkg::CMD_APP,
                    status_word(sdcard_pkg::STBY, 1'b1, 1'b1, 1'b1));
        send_cmd(sdcard_pkg::CMD_APP, 32'd0, 1'b0);
        expect_resp("R1", sdcard_pkg::R1, sdcard_pkg::CMD_APP,
                    status_word(sdcard_pkg::STBY, 1'b0, 1'b0, 1'b1));
    endtask

    task automatic go_idle_again();
        bit          got;
        logic [47:0] f;
        logic [31:0] arg;
        $display("CMD0 from stand-by");
        send_cmd(sdcard_pkg::CMD_GO_IDLE, 32'd0, 1'b0);
        capture_resp(1'b0, got, f);
        check_eq("o_card_state", 32'(o_card_state), 32'(sdcard_pkg::IDLE));
        arg = $random(seed);
        send_cmd(sdcard_pkg::CMD_SEND_IF_COND, arg, 1'b0);
        expect_resp("R7", sdcard_pkg::R7, sdcard_pkg::CMD_SEND_IF_COND, {20'd0, arg[11:0]});
    endtask

    initial begin
        i_nrst = 1'b0;
        i_cmd  = 1'b1;                                  // Host line idles high
        seed   = 5;
        checks = 0;
        errors = 0;
        repeat (3) @(posedge i_clk);
        i_nrst <= 1'b1;
        power_up();
        send_if_cond();
        init_sequence();
        assign_rca();
        error_flags();
        go_idle_again();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: testbench/sdcard_checker.sv
/* Concurrent assertions on the CMD line and the pipeline strobes, bound to the top level */
`default_nettype none

module sdcard_checker (
    input wire i_clk,
    input wire i_nrst,
    input wire i_cmd_out,
    input wire i_cmd_oe,
    input wire i_req_valid,
    input wire i_resp_valid
);

    logic [6:0] oe_run;     // Cycles with the card driving the line

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            oe_run <= '0;
        end else if (i_cmd_oe) begin
            oe_run <= oe_run + 1'b1;
        end else begin
            oe_run <= '0;
        end
    end

    // Released line reads high
    idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_cmd_oe |-> i_cmd_out)
        else $error("CMD line low while the card driver is off");

    resp_after_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |-> $past(i_req_valid))
        else $error("resp_valid without a request one cycle earlier");

    // Gap of two plus a 48-bit frame
    oe_not_long: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cmd_oe |-> (oe_run < 7'd50))
        else $error("o_cmd_oe held for more than 50 cycles");

    oe_exact: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $fell(i_cmd_oe) |-> (oe_run == 7'd50))
        else $error("o_cmd_oe dropped before 50 cycles");

endmodule

bind sdcard_cmd_top sdcard_checker u_checker (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_cmd_out    (o_cmd),
    .i_cmd_oe     (o_cmd_oe),
    .i_req_valid  (req_bus.req_valid),
    .i_resp_valid (resp_bus.resp_valid)
);

`default_nettype wire

// File: logic/sdcard_cmd_top.sv
/* SD card CMD line model top: receiver, controller and transmitter */
`default_nettype none

module sdcard_cmd_top #(
    parameter int          INIT_CLOCKS = 74,
    parameter logic [31:0] OCR_VALUE   = 32'h00FF_8000,   // 2.7 to 3.6 V window
    parameter int          READY_AFTER = 2,
    parameter logic [15:0] RCA_VALUE   = 16'h1234
) (
    input  wire                      i_clk,
    input  wire                      i_nrst,
    input  wire                      i_cmd,       // Host line, idles high
    output logic                     o_cmd,
    output logic                     o_cmd_oe,
    output logic                     o_busy,
    output sdcard_pkg::card_state_t  o_card_state
);

    logic w_tx_active;

    sdcard_req_if  req_bus ();
    sdcard_resp_if resp_bus ();

    sdcard_cmd_rx #(
        .INIT_CLOCKS (INIT_CLOCKS)
    ) u_rx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_cmd       (i_cmd),
        .i_tx_active (w_tx_active),
        .o_busy      (o_busy),
        .req         (req_bus.rx)
    );

    sdcard_cmd_ctrl #(
        .OCR_VALUE   (OCR_VALUE),
        .READY_AFTER (READY_AFTER),
        .RCA_VALUE   (RCA_VALUE)
    ) u_ctrl (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .o_card_state (o_card_state),
        .req          (req_bus.ctrl),
        .resp         (resp_bus.ctrl)
    );

    sdcard_resp_tx u_tx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .o_cmd       (o_cmd),
        .o_cmd_oe    (o_cmd_oe),
        .o_tx_active (w_tx_active),
        .resp        (resp_bus.tx)
    );

endmodule

`default_nettype wire

// File: logic/sdcard_resp_tx.sv
/* Response transmit stage: turnaround gap, frame serializer and CRC7 */
`default_nettype none

module sdcard_resp_tx (
    input  wire        i_clk,
    input  wire        i_nrst,
    output logic       o_cmd,
    output logic       o_cmd_oe,
    output logic       o_tx_active,
    sdcard_resp_if.tx  resp
);

    logic        active;
    logic [5:0]  bit_cnt;       // Bits left, gap included
    logic [49:0] shift;         // Two gap bits then the frame
    logic        is_r3;
    logic        crc_next;
    logic        crc_phase;
    logic [6:0]  crc7;

    // CRC runs over start bit to the last payload bit
    assign crc_next  = active && (bit_cnt <= 6'(sdcard_pkg::FRAME_BITS - 1))
                              && (bit_cnt >= 6'd8);
    assign crc_phase = active && !is_r3 && (bit_cnt <= 6'd7) && (bit_cnt != 6'd0);

    sdcard_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (resp.resp_valid),
        .i_next  (crc_next),
        .i_dat   (shift[49]),
        .o_crc7  (crc7)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            active <= 1'b0;
        end else if (resp.resp_valid) begin
            active <= 1'b1;
        end else if (active && (bit_cnt == 6'd0)) begin
            active <= 1'b0;             // Stop bit done
        end
    end

    always_ff @(posedge i_clk) begin
        if (resp.resp_valid) begin
            bit_cnt <= 6'(sdcard_pkg::FRAME_BITS + 1);
            is_r3   <= (resp.resp_kind == sdcard_pkg::R3);
            // CRC slot and stop bit start as ones
            shift   <= {2'b11, 2'b00,
                        (resp.resp_kind == sdcard_pkg::R3) ? 6'h3F : resp.resp_index,
                        resp.resp_payload, 8'hFF};
        end else if (active) begin
            shift   <= {shift[48:0], 1'b1};
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    always_comb begin
        if (crc_phase) begin
            o_cmd = crc7[bit_cnt[2:0] - 3'd1];  // MSB first
        end else if (active) begin
            o_cmd = shift[49];
        end else begin
            o_cmd = 1'b1;                       // Idle line level
        end
    end

    assign o_cmd_oe    = active;
    assign o_tx_active = active;

endmodule

`default_nettype wire

// File: logic/sdcard_cmd_ctrl.sv
/* Command controller: card state, status flags and response decode */
`default_nettype none

module sdcard_cmd_ctrl #(
    parameter logic [31:0] OCR_VALUE   = 32'h00FF_8000,
    parameter int          READY_AFTER = 2,
    parameter logic [15:0] RCA_VALUE   = 16'h1234
) (
    input  wire                      i_clk,
    input  wire                      i_nrst,
    output sdcard_pkg::card_state_t  o_card_state,
    sdcard_req_if.ctrl               req,
    sdcard_resp_if.ctrl              resp
);

    localparam int CNT_W = $clog2(READY_AFTER + 1);

    sdcard_pkg::card_state_t state;
    logic                    app_flag;          // Next command is an ACMD
    logic                    ill_flag;          // Sticky until reported
    logic                    crc_flag;
    logic [CNT_W-1:0]        op_cnt;            // ACMD41 calls seen
    logic                    op_ready;
    logic [31:0]             status;
    logic                    do_resp;
    logic                    bad_cmd;
    sdcard_pkg::resp_kind_t  kind;
    logic [31:0]             payload;

    // This call completes the init sequence
    assign op_ready = (int'(op_cnt) + 1 >= READY_AFTER) || (state == sdcard_pkg::READY);

    always_comb begin
        status = '0;
        status[sdcard_pkg::STAT_CRC_BIT]     = crc_flag;
        status[sdcard_pkg::STAT_ILLEGAL_BIT] = ill_flag;
        status[12:9]                         = state;
        status[sdcard_pkg::STAT_APP_BIT]     = app_flag;
    end

    always_comb begin
        do_resp = 1'b1;
        bad_cmd = 1'b0;
        kind    = sdcard_pkg::R1;
        payload = status;
        case (req.req_index)
            sdcard_pkg::CMD_GO_IDLE: begin
                do_resp = 1'b0;                 // Silent reset
            end
            sdcard_pkg::CMD_SEND_IF_COND: begin
                kind    = sdcard_pkg::R7;
                payload = {20'd0, req.req_arg[11:0]};   // Voltage and check pattern
                bad_cmd = (state != sdcard_pkg::IDLE);
            end
            sdcard_pkg::CMD_APP: begin
                payload[sdcard_pkg::STAT_APP_BIT] = 1'b1;
            end
            sdcard_pkg::CMD_SEND_OP_COND: begin
                kind        = sdcard_pkg::R3;
                payload     = OCR_VALUE;
                payload[31] = op_ready;         // Power-up done
                bad_cmd = !app_flag ||
                          !(state inside {sdcard_pkg::IDLE, sdcard_pkg::READY});
            end
            sdcard_pkg::CMD_SEND_RCA: begin
                kind    = sdcard_pkg::R6;
                payload = {RCA_VALUE, status[23], status[22], status[19], status[12:0]};
                bad_cmd = !(state inside {sdcard_pkg::READY, sdcard_pkg::IDENT,
                                          sdcard_pkg::STBY});
            end
            default: begin
                bad_cmd = 1'b1;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state           <= sdcard_pkg::IDLE;
            app_flag        <= 1'b0;
            ill_flag        <= 1'b0;
            crc_flag        <= 1'b0;
            op_cnt          <= '0;
            resp.resp_valid <= 1'b0;
        end else begin
            resp.resp_valid <= 1'b0;
            if (req.req_valid) begin
                if (req.req_crc_err) begin
                    crc_flag <= 1'b1;
                end else if (bad_cmd) begin
                    ill_flag <= 1'b1;
                end else begin
                    resp.resp_valid <= do_resp;
                    app_flag        <= (req.req_index == sdcard_pkg::CMD_APP);
                    // R1 and R6 carry the sticky flags
                    if (do_resp && (kind == sdcard_pkg::R1 || kind == sdcard_pkg::R6)) begin
                        ill_flag <= 1'b0;
                        crc_flag <= 1'b0;
                    end
                    case (req.req_index)
                        sdcard_pkg::CMD_GO_IDLE: begin
                            state  <= sdcard_pkg::IDLE;
                            op_cnt <= '0;
                        end
                        sdcard_pkg::CMD_SEND_OP_COND: begin
                            if (op_ready) begin
                                state <= sdcard_pkg::READY;
                            end else begin
                                op_cnt <= op_cnt + 1'b1;
                            end
                        end
                        sdcard_pkg::CMD_SEND_RCA: begin
                            state <= sdcard_pkg::STBY;
                        end
                        default: begin
                            state <= state;
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (req.req_valid) begin
            resp.resp_kind    <= kind;
            resp.resp_index   <= req.req_index;
            resp.resp_payload <= payload;
        end
    end

    assign o_card_state = state;

endmodule

`default_nettype wire

// File: logic/sdcard_cmd_rx.sv
/* Command receive stage: power-up wait, frame deserializer and CRC7 check */
`default_nettype none

module sdcard_cmd_rx #(
    parameter int INIT_CLOCKS = 74
) (
    input  wire        i_clk,
    input  wire        i_nrst,
    input  wire        i_cmd,
    input  wire        i_tx_active,     // Card owns the line
    output logic       o_busy,
    sdcard_req_if.rx   req
);

    typedef enum logic [1:0] {RX_INIT, RX_HUNT, RX_RECV, RX_CHECK} rx_state_t;

    localparam int CNT_W = $clog2(INIT_CLOCKS + 1);

    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [5:0]       bit_cnt;
    logic [46:0]      shift;            // Direction bit down to stop bit
    logic             cmd_z;            // Line level one cycle back
    logic             start_det;
    logic             crc_clear;
    logic             crc_next;
    logic [6:0]       crc_calc;

    // Falling edge on an idle line, ignored while a response goes out
    assign start_det = (state == RX_HUNT) && !i_tx_active && cmd_z && !i_cmd;

    // Start, direction, index and argument go through the CRC
    assign crc_clear = (state == RX_INIT) || (state == RX_CHECK) ||
                       ((state == RX_HUNT) && !start_det);
    assign crc_next  = start_det || ((state == RX_RECV) && (bit_cnt >= 6'd8));

    sdcard_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_dat   (i_cmd),
        .o_crc7  (crc_calc)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state         <= RX_INIT;
            clk_cnt       <= '0;
            cmd_z         <= 1'b0;
            req.req_valid <= 1'b0;
        end else begin
            cmd_z         <= i_cmd;
            req.req_valid <= 1'b0;
            case (state)
                RX_INIT: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CNT_W'(INIT_CLOCKS - 1)) begin
                        state <= RX_HUNT;
                    end
                end
                RX_HUNT: begin
                    if (start_det) begin
                        state <= RX_RECV;
                    end
                end
                RX_RECV: begin
                    if (bit_cnt == '0) begin   // Stop bit sampled
                        state <= RX_CHECK;
                    end
                end
                default: begin
                    // Host-to-card frames with a stop bit only
                    req.req_valid <= shift[46] & shift[0];
                    state         <= RX_HUNT;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_det) begin
            bit_cnt <= 6'(sdcard_pkg::FRAME_BITS - 2);
        end else if (state == RX_RECV) begin
            shift   <= {shift[45:0], i_cmd};
            bit_cnt <= bit_cnt - 1'b1;
        end
        if (state == RX_CHECK) begin
            req.req_index   <= shift[45:40];
            req.req_arg     <= shift[39:8];
            req.req_crc_err <= (crc_calc != shift[7:1]);
        end
    end

    assign o_busy = (state == RX_INIT);

endmodule

`default_nettype wire

// File: logic/sdcard_crc7.sv
/* Serial CRC7 generator, polynomial x^7 + x^3 + 1 */
`default_nettype none

module sdcard_crc7 (
    input  wire        i_clk,
    input  wire        i_nrst,
    input  wire        i_clear,     // Zero the register
    input  wire        i_next,      // Shift in i_dat
    input  wire        i_dat,
    output logic [6:0] o_crc7
);

    logic [6:0] crc;
    logic       fb;

    assign fb = i_dat ^ crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc <= '0;
        end else if (i_clear) begin
            crc <= '0;
        end else if (i_next) begin
            // Feedback enters at taps 0 and 3
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

    assign o_crc7 = crc;

endmodule

`default_nettype wire

// File: logic/sdcard_ifs.sv
/* Request and response interfaces between the pipeline stages */
`default_nettype none

// Decoded command from the receiver, single-cycle strobe
interface sdcard_req_if;
    logic       req_valid;
    logic [5:0] req_index;
    logic [31:0] req_arg;
    logic       req_crc_err;     // Received CRC7 did not match

    modport rx (
        output req_valid, req_index, req_arg, req_crc_err
    );
    modport ctrl (
        input  req_valid, req_index, req_arg, req_crc_err
    );
endinterface

// Response to serialize, single-cycle strobe
interface sdcard_resp_if;
    logic                   resp_valid;
    sdcard_pkg::resp_kind_t resp_kind;
    logic [5:0]             resp_index;
    logic [31:0]            resp_payload;

    modport ctrl (
        output resp_valid, resp_kind, resp_index, resp_payload
    );
    modport tx (
        input  resp_valid, resp_kind, resp_index, resp_payload
    );
endinterface

`default_nettype wire

// File: logic/sdcard_pkg.sv
/* Shared definitions for the SD card CMD line model
   Card states, response kinds, command indices, frame width and status bits */
`default_nettype none

package sdcard_pkg;

    // Values match the CURRENT_STATE field of the card status
    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        READY = 4'd1,
        IDENT = 4'd2,
        STBY  = 4'd3
    } card_state_t;

    // R3 replaces the index and CRC7 with all ones
    typedef enum logic [1:0] {
        R1 = 2'd0,
        R3 = 2'd1,
        R6 = 2'd2,
        R7 = 2'd3
    } resp_kind_t;

    localparam logic [5:0] CMD_GO_IDLE      = 6'd0;
    localparam logic [5:0] CMD_SEND_IF_COND = 6'd8;
    localparam logic [5:0] CMD_APP          = 6'd55;
    localparam logic [5:0] CMD_SEND_OP_COND = 6'd41;   // Only after CMD55
    localparam logic [5:0] CMD_SEND_RCA     = 6'd3;

    localparam int FRAME_BITS = 48;                     // Start to stop bit

    // Positions in the 32-bit card status
    localparam int STAT_CRC_BIT     = 23;
    localparam int STAT_ILLEGAL_BIT = 22;
    localparam int STAT_APP_BIT     = 5;

endpackage

`default_nettype wire
